/* hdl/axi_master_pkg.sv */
`default_nettype none

package axi_master_pkg;

  // bus and line geometry
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int LINE_WORDS = 4;
  localparam int LINE_W     = DATA_W * LINE_WORDS; // one cache line
  localparam int BEAT_IDX_W = 2;
  localparam int AXI_ID_W   = 4;

  // fixed burst shape, one line per burst
  localparam logic [7:0] AXI_LEN_LINE   = 8'd3;   // 4 beats
  localparam logic [2:0] AXI_SIZE_WORD  = 3'd2;   // 4 bytes
  localparam logic [1:0] AXI_BURST_INCR = 2'd1;

  localparam logic [AXI_ID_W-1:0] ID_IFETCH = 4'd0;
  localparam logic [AXI_ID_W-1:0] ID_DATA   = 4'd1;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // burst_fsm states
  localparam int ST_W_BITS = 3;
  localparam logic [ST_W_BITS-1:0] ST_IDLE = 3'd0;
  localparam logic [ST_W_BITS-1:0] ST_AR   = 3'd1;
  localparam logic [ST_W_BITS-1:0] ST_R    = 3'd2;
  localparam logic [ST_W_BITS-1:0] ST_AW   = 3'd3;
  localparam logic [ST_W_BITS-1:0] ST_W    = 3'd4;
  localparam logic [ST_W_BITS-1:0] ST_B    = 3'd5;
  localparam logic [ST_W_BITS-1:0] ST_DONE = 3'd6;

endpackage

`default_nettype wire

/* hdl/refill_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module refill_arbiter import axi_master_pkg::*; (
  input  wire              clk,
  input  wire              rst_n_i,
  input  wire              ifetch_req_i,
  input  wire              data_rd_req_i,
  input  wire              data_wr_req_i,
  input  wire [ADDR_W-1:0] ifetch_addr_i,
  input  wire [ADDR_W-1:0] data_addr_i,
  input  wire              idle_i,
  input  wire              done_i,
  output logic             start_o,
  output logic             is_write_o,
  output logic             grant_data_o,
  output logic [ADDR_W-1:0] addr_o,
  output wire              ifetch_done_o,
  output wire              data_done_o
);

  wire any_req;
  wire data_req;
  wire pick;

  assign data_req = data_wr_req_i | data_rd_req_i;
  assign any_req  = data_req | ifetch_req_i;

  // the fsm still shows idle in the start cycle, so skip it there
  assign pick = idle_i & ~start_o & any_req;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      start_o      <= 1'b0;
      is_write_o   <= 1'b0;
      grant_data_o <= 1'b0;
    end else begin
      start_o <= pick;
      if (pick) begin
        // writeback wins over data read, data side over ifetch
        is_write_o   <= data_wr_req_i;
        grant_data_o <= data_req;
      end
    end
  end

  // address of the winner, held for the whole burst
  always_ff @(posedge clk) begin
    if (pick) begin
      addr_o <= data_req ? data_addr_i : ifetch_addr_i;
    end
  end

  // done goes back only to the side that owns the burst
  assign ifetch_done_o = done_i & ~grant_data_o;
  assign data_done_o   = done_i & grant_data_o;

endmodule

`default_nettype wire

/* hdl/burst_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module burst_fsm import axi_master_pkg::*; (
  input  wire                 clk,
  input  wire                 rst_n_i,
  input  wire                 start_i,
  input  wire                 is_write_i,
  input  wire                 grant_data_i,
  input  wire [ADDR_W-1:0]    addr_i,
  input  wire                 last_beat_i,
  input  wire                 arready_i,
  input  wire                 rvalid_i,
  input  wire                 rlast_i,
  input  wire                 awready_i,
  input  wire                 wready_i,
  input  wire                 bvalid_i,
  output wire                 idle_o,
  output wire                 done_o,
  output wire                 beat_o,
  output wire                 arvalid_o,
  output wire [ADDR_W-1:0]    araddr_o,
  output wire [AXI_ID_W-1:0]  arid_o,
  output wire                 rready_o,
  output wire                 awvalid_o,
  output wire [ADDR_W-1:0]    awaddr_o,
  output wire [AXI_ID_W-1:0]  awid_o,
  output wire                 wvalid_o,
  output wire                 wlast_o,
  output wire                 bready_o
);

  logic [ST_W_BITS-1:0] state_q;
  logic [ST_W_BITS-1:0] state_d;
  wire  [AXI_ID_W-1:0]  id;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d = is_write_i ? ST_AW : ST_AR;
        end
      end
      ST_AR:   if (arready_i)           state_d = ST_R;
      ST_R:    if (rvalid_i && rlast_i) state_d = ST_DONE; // slave marks the end
      ST_AW:   if (awready_i)           state_d = ST_W;
      ST_W: begin
        // our own count decides the last write beat
        if (wready_i && last_beat_i) begin
          state_d = ST_B;
        end
      end
      ST_B:    if (bvalid_i)            state_d = ST_DONE;
      ST_DONE:                          state_d = ST_IDLE;
      default:                          state_d = ST_IDLE;
    endcase
  end

  assign id = grant_data_i ? ID_DATA : ID_IFETCH;

  assign idle_o = (state_q == ST_IDLE);
  assign done_o = (state_q == ST_DONE);

  // address channels, addr_i is held by the arbiter
  assign arvalid_o = (state_q == ST_AR);
  assign araddr_o  = addr_i;
  assign arid_o    = id;
  assign awvalid_o = (state_q == ST_AW);
  assign awaddr_o  = addr_i;
  assign awid_o    = id;

  assign rready_o  = (state_q == ST_R);
  assign wvalid_o  = (state_q == ST_W);
  assign wlast_o   = wvalid_o & last_beat_i;
  assign bready_o  = (state_q == ST_B);

  // one pulse per accepted data beat, read or write
  assign beat_o = (rready_o & rvalid_i) | (wvalid_o & wready_i);

endmodule

`default_nettype wire

/* hdl/beat_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module beat_counter import axi_master_pkg::*; (
  input  wire                   clk,
  input  wire                   rst_n_i,
  input  wire                   clear_i,
  input  wire                   beat_i,
  output logic [BEAT_IDX_W-1:0] beat_idx_o,
  output wire                   last_beat_o
);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      beat_idx_o <= '0;
    end else if (clear_i) begin
      beat_idx_o <= '0;            // new burst
    end else if (beat_i) begin
      beat_idx_o <= beat_idx_o + 1'b1; // wraps after the 4th beat
    end
  end

  assign last_beat_o = (beat_idx_o == BEAT_IDX_W'(LINE_WORDS - 1));

endmodule

`default_nettype wire

/* hdl/line_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module line_buffer import axi_master_pkg::*; (
  input  wire                  clk,
  input  wire                  rst_n_i,
  input  wire                  start_i,
  input  wire                  is_write_i,
  input  wire [LINE_W-1:0]     wline_i,
  input  wire                  beat_i,
  input  wire [BEAT_IDX_W-1:0] beat_idx_i,
  input  wire                  rvalid_i,
  input  wire [DATA_W-1:0]     rdata_i,
  input  wire [1:0]            rresp_i,
  input  wire                  bvalid_i,
  input  wire                  bready_i,
  input  wire [1:0]            bresp_i,
  output wire [DATA_W-1:0]     wdata_o,
  output wire [LINE_W-1:0]     line_o,
  output logic                 err_o
);

  logic [LINE_WORDS-1:0][DATA_W-1:0] line_q; // word 0 in the low bits
  wire  rd_beat;
  wire  rd_err;
  wire  wr_err;

  assign rd_beat = beat_i & rvalid_i & ~is_write_i;
  assign rd_err  = rd_beat & (rresp_i != RESP_OKAY);
  assign wr_err  = bvalid_i & bready_i & (bresp_i != RESP_OKAY);

  always_ff @(posedge clk) begin
    if (start_i && is_write_i) begin
      line_q <= wline_i;           // writeback line from the data side
    end else if (rd_beat) begin
      line_q[beat_idx_i] <= rdata_i;
    end
  end

  // sticky over one burst
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_o <= 1'b0;
    end else if (start_i) begin
      err_o <= 1'b0;
    end else if (rd_err || wr_err) begin
      err_o <= 1'b1;
    end
  end

  assign wdata_o = line_q[beat_idx_i];
  assign line_o  = line_q;

endmodule

`default_nettype wire

/* hdl/axi_master_top.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_master_top import axi_master_pkg::*; (
  input  wire                 clk,
  input  wire                 rst_n_i,
  // ifetch requester, line reads only
  input  wire                 ifetch_req_i,
  input  wire [ADDR_W-1:0]    ifetch_addr_i,
  output wire                 ifetch_done_o,
  output wire [LINE_W-1:0]    ifetch_line_o,
  // data requester, line reads and writebacks
  input  wire                 data_rd_req_i,
  input  wire                 data_wr_req_i,
  input  wire [ADDR_W-1:0]    data_addr_i,
  input  wire [LINE_W-1:0]    data_wline_i,
  output wire                 data_done_o,
  output wire [LINE_W-1:0]    data_rline_o,
  output wire                 err_o,
  // write address
  output wire                 awvalid_o,
  input  wire                 awready_i,
  output wire [ADDR_W-1:0]    awaddr_o,
  output wire [AXI_ID_W-1:0]  awid_o,
  output wire [7:0]           awlen_o,
  output wire [2:0]           awsize_o,
  output wire [1:0]           awburst_o,
  // write data
  output wire                 wvalid_o,
  input  wire                 wready_i,
  output wire [DATA_W-1:0]    wdata_o,
  output wire [DATA_W/8-1:0]  wstrb_o,
  output wire                 wlast_o,
  // write response
  input  wire                 bvalid_i,
  output wire                 bready_o,
  input  wire [1:0]           bresp_i,
  input  wire [AXI_ID_W-1:0]  bid_i,   // one burst in flight, id never compared
  // read address
  output wire                 arvalid_o,
  input  wire                 arready_i,
  output wire [ADDR_W-1:0]    araddr_o,
  output wire [AXI_ID_W-1:0]  arid_o,
  output wire [7:0]           arlen_o,
  output wire [2:0]           arsize_o,
  output wire [1:0]           arburst_o,
  // read data
  input  wire                 rvalid_i,
  output wire                 rready_o,
  input  wire [DATA_W-1:0]    rdata_i,
  input  wire [1:0]           rresp_i,
  input  wire                 rlast_i,
  input  wire [AXI_ID_W-1:0]  rid_i    // same as bid_i
);

  wire                  start;
  wire                  is_write;
  wire                  grant_data;
  wire [ADDR_W-1:0]     addr;
  wire                  idle;
  wire                  done;
  wire                  beat;
  wire [BEAT_IDX_W-1:0] beat_idx;
  wire                  last_beat;
  wire [LINE_W-1:0]     line;

  // burst shape is the same for every transfer
  assign awlen_o   = AXI_LEN_LINE;
  assign awsize_o  = AXI_SIZE_WORD;
  assign awburst_o = AXI_BURST_INCR;
  assign arlen_o   = AXI_LEN_LINE;
  assign arsize_o  = AXI_SIZE_WORD;
  assign arburst_o = AXI_BURST_INCR;
  assign wstrb_o   = {(DATA_W/8){1'b1}}; // full lines only

  assign ifetch_line_o = line;
  assign data_rline_o  = line;

  refill_arbiter u_refill_arbiter (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .ifetch_req_i  (ifetch_req_i),
    .data_rd_req_i (data_rd_req_i),
    .data_wr_req_i (data_wr_req_i),
    .ifetch_addr_i (ifetch_addr_i),
    .data_addr_i   (data_addr_i),
    .idle_i        (idle),
    .done_i        (done),
    .start_o       (start),
    .is_write_o    (is_write),
    .grant_data_o  (grant_data),
    .addr_o        (addr),
    .ifetch_done_o (ifetch_done_o),
    .data_done_o   (data_done_o)
  );

  burst_fsm u_burst_fsm (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .start_i      (start),
    .is_write_i   (is_write),
    .grant_data_i (grant_data),
    .addr_i       (addr),
    .last_beat_i  (last_beat),
    .arready_i    (arready_i),
    .rvalid_i     (rvalid_i),
    .rlast_i      (rlast_i),
    .awready_i    (awready_i),
    .wready_i     (wready_i),
    .bvalid_i     (bvalid_i),
    .idle_o       (idle),
    .done_o       (done),
    .beat_o       (beat),
    .arvalid_o    (arvalid_o),
    .araddr_o     (araddr_o),
    .arid_o       (arid_o),
    .rready_o     (rready_o),
    .awvalid_o    (awvalid_o),
    .awaddr_o     (awaddr_o),
    .awid_o       (awid_o),
    .wvalid_o     (wvalid_o),
    .wlast_o      (wlast_o),
    .bready_o     (bready_o)
  );

  beat_counter u_beat_counter (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .clear_i     (start),
    .beat_i      (beat),
    .beat_idx_o  (beat_idx),
    .last_beat_o (last_beat)
  );

  line_buffer u_line_buffer (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .start_i    (start),
    .is_write_i (is_write),
    .wline_i    (data_wline_i),
    .beat_i     (beat),
    .beat_idx_i (beat_idx),
    .rvalid_i   (rvalid_i),
    .rdata_i    (rdata_i),
    .rresp_i    (rresp_i),
    .bvalid_i   (bvalid_i),
    .bready_i   (bready_o),
    .bresp_i    (bresp_i),
    .wdata_o    (wdata_o),
    .line_o     (line),
    .err_o      (err_o)
  );

endmodule

`default_nettype wire

/* bench/axi_slave_model.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_slave_model import axi_master_pkg::*; (
  input  wire                 clk,
  input  wire                 rst_n_i,
  input  wire                 awvalid_i,
  output logic                awready_o,
  input  wire  [ADDR_W-1:0]   awaddr_i,
  input  wire  [AXI_ID_W-1:0] awid_i,
  input  wire                 wvalid_i,
  output logic                wready_o,
  input  wire  [DATA_W-1:0]   wdata_i,
  output logic                bvalid_o,
  input  wire                 bready_i,
  output logic [1:0]          bresp_o,
  output logic [AXI_ID_W-1:0] bid_o,
  input  wire                 arvalid_i,
  output logic                arready_o,
  input  wire  [ADDR_W-1:0]   araddr_i,
  input  wire  [AXI_ID_W-1:0] arid_i,
  output logic                rvalid_o,
  input  wire                 rready_i,
  output logic [DATA_W-1:0]   rdata_o,
  output logic [1:0]          rresp_o,
  output logic                rlast_o,
  output logic [AXI_ID_W-1:0] rid_o
);

  logic [DATA_W-1:0] mem [0:1023]; // 4 KiB, word 0 at address 0
  logic [15:0]       lfsr;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // taps 16 14 13 11
  endfunction

  // SLVERR on the one faulty line
  function automatic logic [1:0] resp_for(input logic [ADDR_W-1:0] a);
    return (a == 32'h0000_0F00) ? 2'b10 : 2'b00;
  endfunction

  // back at the drive point, 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic random_stall();
    int n;
    n = 0;
    repeat (2) begin
      lfsr = lfsr_next(lfsr);
      n = 2 * n + int'(lfsr[0]);   // one step per bit
    end
    repeat (n) next_cycle();
  endtask

  task automatic serve_read();
    logic [ADDR_W-1:0] a;
    logic [9:0]        idx;
    random_stall();
    arready_o = 1'b1;
    a = araddr_i;
    rid_o = arid_i;
    next_cycle();
    arready_o = 1'b0;
    for (int b = 0; b < LINE_WORDS; b++) begin
      random_stall();
      idx = a[11:2] + 10'(b);
      rvalid_o = 1'b1;
      rdata_o  = mem[idx];
      rresp_o  = resp_for(a);
      rlast_o  = (b == LINE_WORDS - 1);
      while (!rready_i) next_cycle();
      next_cycle();                // beat taken at that edge
      rvalid_o = 1'b0;
      rlast_o  = 1'b0;
    end
  endtask

  task automatic serve_write();
    logic [ADDR_W-1:0] a;
    logic [9:0]        idx;
    random_stall();
    awready_o = 1'b1;
    a = awaddr_i;
    bid_o = awid_i;
    next_cycle();
    awready_o = 1'b0;
    for (int b = 0; b < LINE_WORDS; b++) begin
      random_stall();
      wready_o = 1'b1;
      while (!wvalid_i) next_cycle();
      idx = a[11:2] + 10'(b);
      mem[idx] = wdata_i;
      next_cycle();
      wready_o = 1'b0;
    end
    random_stall();
    bvalid_o = 1'b1;
    bresp_o  = resp_for(a);
    while (!bready_i) next_cycle();
    next_cycle();
    bvalid_o = 1'b0;
  endtask

  initial begin
    lfsr      = 16'd38;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bvalid_o  = 1'b0;
    bresp_o   = 2'b00;
    bid_o     = '0;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    rresp_o   = 2'b00;
    rlast_o   = 1'b0;
    rid_o     = '0;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = i ^ 32'hA5A5_0000;  // word address in the low half
    end
    forever begin
      next_cycle();
      if (rst_n_i && awvalid_i) begin
        serve_write();
      end else if (rst_n_i && arvalid_i) begin
        serve_read();
      end
    end
  end

endmodule

`default_nettype wire

/* bench/axi_master_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_master_tb import axi_master_pkg::*; ();

  logic              clk;
  logic              rst_n_i;
  logic              ifetch_req_i;
  logic [ADDR_W-1:0] ifetch_addr_i;
  logic              data_rd_req_i;
  logic              data_wr_req_i;
  logic [ADDR_W-1:0] data_addr_i;
  logic [LINE_W-1:0] data_wline_i;
  wire               ifetch_done_o, data_done_o, err_o;
  wire  [LINE_W-1:0] ifetch_line_o, data_rline_o;
  wire               awvalid_o, awready_i, wvalid_o, wready_i, wlast_o, bvalid_i, bready_o;
  wire               arvalid_o, arready_i, rvalid_i, rready_o, rlast_i;
  wire  [ADDR_W-1:0] awaddr_o, araddr_o;
  wire  [AXI_ID_W-1:0] awid_o, arid_o, bid_i, rid_i;
  wire  [7:0]        awlen_o, arlen_o;
  wire  [2:0]        awsize_o, arsize_o;
  wire  [1:0]        awburst_o, arburst_o, bresp_i, rresp_i;
  wire  [DATA_W-1:0] wdata_o, rdata_i;
  wire  [DATA_W/8-1:0] wstrb_o;

  logic [DATA_W-1:0]        shadow [logic [ADDR_W-1:0]]; // written words by word address
  logic [AXI_ID_W+ADDR_W:0] hs_q [$];                    // {is_aw, id, addr} per handshake
  string                    test_name;
  int test_errs, total_errs, tests_run, tests_bad;
  int ifetch_dones, data_dones, stalls, stall_base, ifetch_base, data_base;
  int w_beats;
  logic                     ar_wait, aw_wait, w_wait;
  logic [ADDR_W-1:0]        ar_addr_q, aw_addr_q;
  logic [DATA_W-1:0]        wdata_q;
  logic                     wlast_q;

  axi_master_top axi_master_top_i (.*);

  axi_slave_model u_slave (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .awvalid_i (awvalid_o),
    .awready_o (awready_i),
    .awaddr_i  (awaddr_o),
    .awid_i    (awid_o),
    .wvalid_i  (wvalid_o),
    .wready_o  (wready_i),
    .wdata_i   (wdata_o),
    .bvalid_o  (bvalid_i),
    .bready_i  (bready_o),
    .bresp_o   (bresp_i),
    .bid_o     (bid_i),
    .arvalid_i (arvalid_o),
    .arready_o (arready_i),
    .araddr_i  (araddr_o),
    .arid_i    (arid_o),
    .rvalid_o  (rvalid_i),
    .rready_i  (rready_o),
    .rdata_o   (rdata_i),
    .rresp_o   (rresp_i),
    .rlast_o   (rlast_i),
    .rid_o     (rid_i)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // memory image as the requesters should see it
  function automatic logic [LINE_W-1:0] expected_line(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] wa;
    logic [LINE_W-1:0] exp_line;
    exp_line = '0;
    for (int w = 0; w < LINE_WORDS; w++) begin
      wa = (addr >> 2) + ADDR_W'(w);
      exp_line[w*DATA_W +: DATA_W] = shadow.exists(wa) ? shadow[wa] : (wa ^ 32'hA5A5_0000);
    end
    return exp_line;
  endfunction

  function automatic logic [LINE_W-1:0] make_line(input logic [15:0] tag);
    return {tag, 16'd3, tag, 16'd2, tag, 16'd1, tag, 16'd0};
  endfunction

  task automatic value_error(input string what, input logic [LINE_W-1:0] exp,
                             input logic [LINE_W-1:0] act);
    $display("ERROR %s: %s expected %0h actual %0h", test_name, what, exp, act);
    test_errs++;
    total_errs++;
  endtask

  task automatic protocol_error(input string msg);
    $display("%s: %s", test_name, msg);
    test_errs++;
    total_errs++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
    hs_q.delete();
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", test_name, test_errs);
    end
  endtask

  task automatic check_quiet();
    if ({awvalid_o, wvalid_o, arvalid_o, rready_o, bready_o, ifetch_done_o, data_done_o} != 0)
      value_error("valids, readies and dones", 0,
                  {awvalid_o, wvalid_o, arvalid_o, rready_o, bready_o, ifetch_done_o,
                   data_done_o});
  endtask

  // requester tasks start and end 1 ns after a rising edge
  task automatic ifetch_read(input logic [ADDR_W-1:0] a);
    ifetch_addr_i = a;
    ifetch_req_i  = 1'b1;
    @(negedge clk);
    while (!ifetch_done_o) @(negedge clk);
    @(posedge clk);
    #1;
    ifetch_req_i = 1'b0;
  endtask

  task automatic data_read(input logic [ADDR_W-1:0] a);
    data_addr_i   = a;
    data_rd_req_i = 1'b1;
    @(negedge clk);
    while (!data_done_o) @(negedge clk);
    @(posedge clk);
    #1;
    data_rd_req_i = 1'b0;
  endtask

  task automatic data_write(input logic [ADDR_W-1:0] a, input logic [LINE_W-1:0] l);
    data_addr_i   = a;
    data_wline_i  = l;
    data_wr_req_i = 1'b1;
    @(negedge clk);
    while (!data_done_o) @(negedge clk);
    @(posedge clk);
    #1;
    data_wr_req_i = 1'b0;
  endtask

  // both data requests raised at once and the writeback served first
  task automatic data_write_read(input logic [ADDR_W-1:0] a, input logic [LINE_W-1:0] l);
    data_addr_i   = a;
    data_wline_i  = l;
    data_wr_req_i = 1'b1;
    data_rd_req_i = 1'b1;
    @(negedge clk);
    while (!data_done_o) @(negedge clk);
    @(posedge clk);
    #1;
    data_wr_req_i = 1'b0;
    @(negedge clk);
    while (!data_done_o) @(negedge clk);
    @(posedge clk);
    #1;
    data_rd_req_i = 1'b0;
  endtask

  // bus monitor sampling at the falling edge where all is stable
  always @(negedge clk) begin
    if (!rst_n_i) begin
      ar_wait = 1'b0;
      aw_wait = 1'b0;
      w_wait  = 1'b0;
      w_beats = 0;
    end else begin
      if (ar_wait && (!arvalid_o || araddr_o != ar_addr_q))
        protocol_error("arvalid dropped or araddr changed before arready");
      if (aw_wait && (!awvalid_o || awaddr_o != aw_addr_q))
        protocol_error("awvalid dropped or awaddr changed before awready");
      if (w_wait && (!wvalid_o || wdata_o != wdata_q || wlast_o != wlast_q))
        protocol_error("wvalid dropped or wdata/wlast changed before wready");
      if (arvalid_o && arready_i) begin
        hs_q.push_back({1'b0, arid_o, araddr_o});
        if ({arlen_o, arsize_o, arburst_o} != {8'd3, 3'd2, 2'd1})
          value_error("arlen/arsize/arburst", {8'd3, 3'd2, 2'd1},
                      {arlen_o, arsize_o, arburst_o});
      end
      if (awvalid_o && awready_i) begin
        hs_q.push_back({1'b1, awid_o, awaddr_o});
        if ({awlen_o, awsize_o, awburst_o} != {8'd3, 3'd2, 2'd1})
          value_error("awlen/awsize/awburst", {8'd3, 3'd2, 2'd1},
                      {awlen_o, awsize_o, awburst_o});
      end
      if (wvalid_o && wready_i) begin
        if (wstrb_o != 4'hF) value_error("wstrb", 4'hF, wstrb_o);
        if (wlast_o != (w_beats == 3)) value_error("wlast", (w_beats == 3), wlast_o);
        w_beats = (w_beats == 3) ? 0 : w_beats + 1;
      end
      ar_wait   = arvalid_o && !arready_i;
      aw_wait   = awvalid_o && !awready_i;
      w_wait    = wvalid_o && !wready_i;
      stalls    = stalls + int'(ar_wait) + int'(aw_wait) + int'(w_wait);
      ar_addr_q = araddr_o;
      aw_addr_q = awaddr_o;
      wdata_q   = wdata_o;
      wlast_q   = wlast_o;
    end
  end

  // compare each done against the reference
  always @(negedge clk) begin
    if (rst_n_i && ifetch_done_o) begin
      ifetch_dones++;
      if (ifetch_line_o != expected_line(ifetch_addr_i))
        value_error("ifetch_line_o", expected_line(ifetch_addr_i), ifetch_line_o);
      if (err_o != (ifetch_addr_i == 32'h0000_0F00))
        value_error("err_o", (ifetch_addr_i == 32'h0000_0F00), err_o);
    end
    if (rst_n_i && data_done_o) begin
      data_dones++;
      if (data_wr_req_i) begin
        for (int w = 0; w < LINE_WORDS; w++) begin
          shadow[(data_addr_i >> 2) + ADDR_W'(w)] = data_wline_i[w*DATA_W +: DATA_W];
        end
      end else if (data_rline_o != expected_line(data_addr_i)) begin
        value_error("data_rline_o", expected_line(data_addr_i), data_rline_o);
      end
      if (err_o != (data_addr_i == 32'h0000_0F00))
        value_error("err_o", (data_addr_i == 32'h0000_0F00), err_o);
    end
  end

  // 200 cycles for each of the 14 transfers
  initial begin
    #(14 * 200 * 10);
    $display("timeout: a transfer never finished");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    rst_n_i       = 1'b0;
    ifetch_req_i  = 1'b0;
    ifetch_addr_i = '0;
    data_rd_req_i = 1'b0;
    data_wr_req_i = 1'b0;
    data_addr_i   = '0;
    data_wline_i  = '0;

    start_test("reset");
    #1;
    check_quiet();
    @(negedge clk);
    check_quiet();
    @(posedge clk);
    #1;
    rst_n_i = 1'b1;                // after two rising edges
    @(negedge clk);
    check_quiet();
    @(posedge clk);
    #1;
    end_test();

    start_test("ifetch_read");
    ifetch_read(32'h0000_0100);
    if (hs_q.size() != 1) protocol_error("expected exactly one AR handshake");
    else if (hs_q[0] != {1'b0, 4'd0, 32'h0000_0100})
      value_error("AR {aw,id,addr}", {1'b0, 4'd0, 32'h0000_0100}, hs_q[0]);
    end_test();

    start_test("write_then_read");
    data_write(32'h0000_0400, make_line(16'h1111));
    data_read(32'h0000_0400);
    if (data_rline_o != make_line(16'h1111))
      value_error("read back line", make_line(16'h1111), data_rline_o);
    end_test();

    start_test("priority");
    ifetch_base = ifetch_dones;
    data_base   = data_dones;
    fork
      ifetch_read(32'h0000_0200);
      data_write_read(32'h0000_0300, make_line(16'h2222));
    join
    if (hs_q.size() != 3) begin
      protocol_error("expected three address handshakes");
    end else begin
      if (hs_q[0] != {1'b1, 4'd1, 32'h0000_0300})
        value_error("1st handshake", {1'b1, 4'd1, 32'h0000_0300}, hs_q[0]);
      if (hs_q[1] != {1'b0, 4'd1, 32'h0000_0300})
        value_error("2nd handshake", {1'b0, 4'd1, 32'h0000_0300}, hs_q[1]);
      if (hs_q[2] != {1'b0, 4'd0, 32'h0000_0200})
        value_error("3rd handshake", {1'b0, 4'd0, 32'h0000_0200}, hs_q[2]);
    end
    if (ifetch_dones - ifetch_base != 1)
      value_error("ifetch dones", 1, ifetch_dones - ifetch_base);
    if (data_dones - data_base != 2)
      value_error("data dones", 2, data_dones - data_base);
    end_test();

    start_test("back_pressure");
    stall_base = stalls;
    for (int i = 0; i < 2; i++) begin
      data_write(32'h0000_0500 + 32'(i * 64), make_line(16'h3300 + 16'(i)));
      ifetch_read(32'h0000_0500 + 32'(i * 64));
      data_read(32'h0000_0800 + 32'(i * 16));
    end
    if (stalls == stall_base) protocol_error("no address or write stall was seen");
    end_test();

    start_test("error_response");
    data_read(32'h0000_0F00);      // err_o checked at each done
    ifetch_read(32'h0000_0120);
    end_test();

    $display("%0d tests run, %0d with errors, %0d errors in total",
             tests_run, tests_bad, total_errs);
    if (total_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* axi_master.f */
hdl/axi_master_pkg.sv
hdl/refill_arbiter.sv
hdl/burst_fsm.sv
hdl/beat_counter.sv
hdl/line_buffer.sv
hdl/axi_master_top.sv
bench/axi_slave_model.sv
bench/axi_master_tb.sv

/* Makefile */
TOP := axi_master_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f axi_master.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
